//--- files.f
+incdir+hdl
hdl/eth_xover_pkg.sv
hdl/eth_pkt_rd_if.sv
hdl/eth_packet_store.sv
hdl/eth_frame_len_queue.sv
hdl/eth_byte_counter.sv
hdl/eth_unpack_fsm.sv
hdl/eth_rx_frame_buffer.sv
tb/tb_eth_rx_frame_buffer.sv

//--- run_sim.sh
#!/bin/sh
# Build the frame buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	-f files.f \
	--top-module tb_eth_rx_frame_buffer \
	-Mdir obj_dir \
	-o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# Whole line match on the pass message
if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tb/tb_eth_rx_frame_buffer.sv
`include "eth_xover_consts.svh"

module tb_eth_rx_frame_buffer;

	timeunit 1ns;
	timeprecision 1ps;

	typedef logic [7:0] byte_q_t[$];
	typedef logic [31:0] word_q_t[$];

	logic			rx_clk = 1'b0;
	logic			rst_n;
	logic			rx_start;
	logic			rx_data_valid;
	logic [2:0]		rx_bytes_valid;
	logic [31:0]	rx_data;
	logic			rx_commit;
	logic			rx_drop;
	logic			tx_ready;
	logic			tx_start;
	logic			tx_data_valid;
	logic [7:0]		tx_data;

	// Sender side
	logic [15:0]	lfsr_state;
	int				words_sent;
	int				frames_admitted;
	int				timeout_errors;
	int				count_errors;

	// Expected output pushed by the sender and read in order by the monitor
	logic [7:0]		exp_bytes[$];
	int				exp_lens[$];

	// Monitor side
	int				exp_frame_idx = 0;
	int				exp_byte_idx = 0;
	int				cur_len = 0;
	int				cur_count = 0;
	bit				frame_open = 1'b0;
	bit				ready_prev = 1'b0;
	int				starts_seen = 0;
	int				words_drained = 0;
	int				mismatch_errors = 0;
	int				protocol_errors = 0;

	eth_rx_frame_buffer dut0 (
		.rx_clk			(rx_clk),
		.rst_n			(rst_n),
		.rx_start		(rx_start),
		.rx_data_valid	(rx_data_valid),
		.rx_bytes_valid	(rx_bytes_valid),
		.rx_data		(rx_data),
		.rx_commit		(rx_commit),
		.rx_drop		(rx_drop),
		.tx_ready		(tx_ready),
		.tx_start		(tx_start),
		.tx_data_valid	(tx_data_valid),
		.tx_data		(tx_data)
	);

	// 8 ns period
	always #4 rx_clk = ~rx_clk;

	//////////////////////////////
	// Random numbers and reference

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0]	v;
		int				i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Frame bytes in send order with the MSB of each word first
	function automatic byte_q_t ref_frame_bytes(input word_q_t words, input int len);
		byte_q_t	q;
		int			i;
		for (i = 0; i < len; i++)
			q.push_back(words[i / 4][31 - 8 * (i % 4) -: 8]);
		return q;
	endfunction

	// Room for a max size frame and a free length slot
	function automatic bit ref_admit(input int used_words, input int queued);
		return ((`ETH_STORE_DEPTH - used_words) >= `ETH_MAX_FRAME_WORDS) &&
			(queued < `ETH_LEN_DEPTH);
	endfunction

	// All expected frames fully seen
	function automatic bit output_drained();
		return (exp_frame_idx >= exp_lens.size()) && (!frame_open || cur_count == cur_len);
	endfunction

	//////////////////////////////
	// Stimulus

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge rx_clk);
		#1;
	endtask

	// Start strobe and words with commit or drop on a cycle of its own
	task automatic send_frame(input int len, input bit drop_it);
		word_q_t	words;
		byte_q_t	frame_q;
		int			nwords;
		int			i;
		bit			admitted;
		nwords = (len + 3) / 4;
		for (i = 0; i < nwords; i++)
			words.push_back(rand_bits(32));
		admitted = ref_admit(words_sent - words_drained, frames_admitted - starts_seen);

		rx_start = 1'b1;
		next_cycle();
		rx_start = 1'b0;
		for (i = 0; i < nwords; i++) begin
			rx_data_valid = 1'b1;
			// Last word may be partial
			rx_bytes_valid = (i == nwords - 1) ? 3'(len - 4 * i) : 3'd4;
			rx_data = words[i];
			next_cycle();
		end
		rx_data_valid = 1'b0;
		rx_bytes_valid = 3'd0;
		rx_data = '0;
		if (drop_it)
			rx_drop = 1'b1;
		else
			rx_commit = 1'b1;
		next_cycle();
		rx_drop = 1'b0;
		rx_commit = 1'b0;

		// Refused and dropped frames expect nothing
		if (admitted && !drop_it) begin
			frame_q = ref_frame_bytes(words, len);
			foreach (frame_q[k])
				exp_bytes.push_back(frame_q[k]);
			exp_lens.push_back(len);
			words_sent += nwords;
			frames_admitted++;
		end
	endtask

	task automatic wait_drain(input int limit, output bit ok);
		int cycles;
		cycles = 0;
		ok = 1'b1;
		while (!output_drained()) begin
			if (cycles >= limit) begin
				timeout_errors++;
				$display("timeout after %0d cycles with frames still expected on the output",
					limit);
				ok = 1'b0;
				return;
			end
			next_cycle();
			cycles++;
		end
	endtask

	task automatic check_frame_count(input int base, input int expected);
		if (starts_seen - base != expected) begin
			count_errors++;
			$display("mismatch at %0t: %0d frames sent out, expected %0d",
				$time, starts_seen - base, expected);
		end
	endtask

	task automatic run_all();
		bit	ok;
		int	i;
		int	base;
		// Empty buffer stays quiet after reset
		repeat (4) next_cycle();

		// Random lengths with the MAC always ready
		tx_ready = 1'b1;
		for (i = 0; i < 24; i++)
			send_frame(int'(rand_bits(6)) + 1, 1'b0);
		wait_drain(20000, ok);
		if (!ok)
			return;

		// Dropped frame between two kept ones
		send_frame(int'(rand_bits(6)) + 1, 1'b0);
		send_frame(int'(rand_bits(6)) + 1, 1'b1);
		send_frame(int'(rand_bits(6)) + 1, 1'b0);
		wait_drain(2000, ok);
		if (!ok)
			return;

		// Store fills so the third max size frame is refused
		tx_ready = 1'b0;
		base = starts_seen;
		for (i = 0; i < 3; i++)
			send_frame(1500, 1'b0);
		tx_ready = 1'b1;
		wait_drain(10000, ok);
		if (!ok)
			return;
		// Room for a refused frame to start by mistake
		repeat (16) next_cycle();
		check_frame_count(base, 2);

		// Space back after the pops
		base = starts_seen;
		send_frame(1500, 1'b0);
		wait_drain(5000, ok);
		if (!ok)
			return;
		repeat (16) next_cycle();
		check_frame_count(base, 1);

		// Length queue fills so frame 65 is refused
		tx_ready = 1'b0;
		base = starts_seen;
		for (i = 0; i < 65; i++)
			send_frame(4, 1'b0);
		tx_ready = 1'b1;
		wait_drain(5000, ok);
		if (!ok)
			return;

		// Refused frames must not turn up late
		repeat (64) next_cycle();
		check_frame_count(base, 64);
	endtask

	initial begin
		rst_n = 1'b0;
		rx_start = 1'b0;
		rx_data_valid = 1'b0;
		rx_bytes_valid = 3'd0;
		rx_data = '0;
		rx_commit = 1'b0;
		rx_drop = 1'b0;
		tx_ready = 1'b0;
		lfsr_state = 16'd59;
		words_sent = 0;
		frames_admitted = 0;
		timeout_errors = 0;
		count_errors = 0;

		repeat (10) @(posedge rx_clk);
		#1;
		rst_n = 1'b1;

		run_all();

		$display("errors: %0d mismatch, %0d protocol, %0d count, %0d timeout",
			mismatch_errors, protocol_errors, count_errors, timeout_errors);
		if (mismatch_errors + protocol_errors + count_errors + timeout_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	//////////////////////////////
	// Output monitor

	// Sampled on the falling edge where outputs are settled
	always @(negedge rx_clk) begin
		if (!rst_n) begin
			if (tx_start || tx_data_valid) begin
				protocol_errors++;
				$display("transmit output active during reset at %0t", $time);
			end
		end else begin
			if (tx_start) begin
				starts_seen++;
				// tx_ready gates the pop one cycle earlier
				if (!ready_prev) begin
					protocol_errors++;
					$display("frame started while tx_ready was low at %0t", $time);
				end
				if (frame_open && cur_count != cur_len) begin
					protocol_errors++;
					$display("frame %0d ended after %0d of %0d bytes at %0t",
						exp_frame_idx - 1, cur_count, cur_len, $time);
				end
				if (exp_frame_idx >= exp_lens.size()) begin
					protocol_errors++;
					$display("frame started with none expected at %0t", $time);
					frame_open = 1'b0;
				end else begin
					cur_len = exp_lens[exp_frame_idx];
					exp_frame_idx++;
					cur_count = 0;
					frame_open = 1'b1;
				end
			end
			if (tx_data_valid) begin
				if (!frame_open || cur_count >= cur_len) begin
					protocol_errors++;
					$display("byte outside an expected frame at %0t", $time);
				end else begin
					if (tx_data !== exp_bytes[exp_byte_idx]) begin
						mismatch_errors++;
						$display("mismatch at %0t: frame %0d byte %0d got %02h expected %02h",
							$time, exp_frame_idx - 1, cur_count, tx_data,
							exp_bytes[exp_byte_idx]);
					end
					exp_byte_idx++;
					cur_count++;
					// Store frees the packet with its last byte
					if (cur_count == cur_len)
						words_drained += (cur_len + 3) / 4;
				end
			end
		end
		ready_prev = tx_ready;
	end

endmodule

//--- hdl/eth_rx_frame_buffer.sv
`include "eth_xover_consts.svh"

module eth_rx_frame_buffer import eth_xover_pkg::*; (
	input	logic							rx_clk,
	input	logic							rst_n,
	input	logic							rx_start,
	input	logic							rx_data_valid,
	input	logic [2:0]						rx_bytes_valid,
	input	logic [`ETH_WORD_BITS-1:0]		rx_data,
	input	logic							rx_commit,
	input	logic							rx_drop,
	input	logic							tx_ready,
	output	logic							tx_start,
	output	logic							tx_data_valid,
	output	logic [7:0]						tx_data
);

	eth_rx_bus_t						rx_bus;
	logic								admit;
	logic [`ETH_STORE_ADDR_BITS:0]		free_words;
	logic								len_pop;
	logic								len_empty;
	logic [`ETH_LEN_BITS-1:0]			len_data;
	logic [`ETH_LEN_BITS-1:0]			frame_len;
	logic								frame_begin;
	logic								lane_step;
	logic								word_step;
	logic								last_byte;
	logic								frame_done;
	byte_lane_t							lane;
	logic [`ETH_STORE_ADDR_BITS-1:0]	word_offset;

	eth_pkt_rd_if rd_if ();

	// Receive pins into one bus
	assign rx_bus = '{
		start:			rx_start,
		data_valid:		rx_data_valid,
		bytes_valid:	rx_bytes_valid,
		data:			rx_data,
		commit:			rx_commit,
		drop:			rx_drop
	};

	//////////////////////////////
	// Receive side

	eth_frame_len_queue len_queue0 (
		.rx_clk		(rx_clk),
		.rst_n		(rst_n),
		.rx_bus		(rx_bus),
		.free_words	(free_words),
		.len_pop	(len_pop),
		.admit		(admit),
		.len_empty	(len_empty),
		.len_data	(len_data)
	);

	eth_packet_store store0 (
		.rx_clk		(rx_clk),
		.rst_n		(rst_n),
		.rx_bus		(rx_bus),
		.admit		(admit),
		.free_words	(free_words),
		.rd			(rd_if)
	);

	//////////////////////////////
	// Transmit side

	eth_byte_counter counter0 (
		.rx_clk			(rx_clk),
		.rst_n			(rst_n),
		.frame_begin	(frame_begin),
		.lane_step		(lane_step),
		.word_step		(word_step),
		.frame_len		(frame_len),
		.lane			(lane),
		.word_offset	(word_offset),
		.last_byte		(last_byte),
		.frame_done		(frame_done)
	);

	eth_unpack_fsm unpack0 (
		.rx_clk			(rx_clk),
		.rst_n			(rst_n),
		.tx_ready		(tx_ready),
		.len_empty		(len_empty),
		.len_data		(len_data),
		.lane			(lane),
		.word_offset	(word_offset),
		.last_byte		(last_byte),
		.frame_done		(frame_done),
		.len_pop		(len_pop),
		.frame_begin	(frame_begin),
		.lane_step		(lane_step),
		.word_step		(word_step),
		.frame_len		(frame_len),
		.tx_start		(tx_start),
		.tx_data_valid	(tx_data_valid),
		.tx_data		(tx_data),
		.rd				(rd_if)
	);

endmodule

//--- hdl/eth_unpack_fsm.sv
`include "eth_xover_consts.svh"

module eth_unpack_fsm import eth_xover_pkg::*; (
	input	logic								rx_clk,
	input	logic								rst_n,
	input	logic								tx_ready,
	input	logic								len_empty,
	input	logic [`ETH_LEN_BITS-1:0]			len_data,
	input	byte_lane_t							lane,
	input	logic [`ETH_STORE_ADDR_BITS-1:0]	word_offset,
	input	logic								last_byte,
	input	logic								frame_done,
	output	logic								len_pop,
	output	logic								frame_begin,
	output	logic								lane_step,
	output	logic								word_step,
	output	logic [`ETH_LEN_BITS-1:0]			frame_len,
	output	logic								tx_start,
	output	logic								tx_data_valid,
	output	logic [7:0]							tx_data,
	eth_pkt_rd_if.reader						rd
);

	localparam int unsigned ADDR_BITS = `ETH_STORE_ADDR_BITS;
	localparam int unsigned LEN_BITS = `ETH_LEN_BITS;

	unpack_state_t	state;
	unpack_state_t	state_next;

	//////////////////////////////
	// State and frame length

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n)
			state	<= UNPACK_IDLE;
		else
			state	<= state_next;
	end

	// Length of the frame being sent, taken as it pops
	always_ff @(posedge rx_clk) begin
		if (len_pop)
			frame_len	<= len_data;
	end

	always_comb begin
		state_next = state;
		case (state)
			// Wait for a queued frame and a ready MAC
			UNPACK_IDLE:
				if (len_pop)
					state_next = UNPACK_LEN_WAIT;
			// Start marker goes out here
			UNPACK_LEN_WAIT:
				state_next = UNPACK_DATA_WAIT;
			// First word read issued
			UNPACK_DATA_WAIT:
				state_next = UNPACK_DATA_FIRST;
			// Gap between words, zero length frames end here
			UNPACK_DATA_FIRST:
				state_next = frame_done ? UNPACK_IDLE : UNPACK_DATA_REST;
			// One byte per cycle, lanes 0 to 3
			UNPACK_DATA_REST:
				if (last_byte)
					state_next = UNPACK_IDLE;
				else if (lane == 2'd3)
					state_next = UNPACK_DATA_FIRST;
			default:
				state_next = UNPACK_IDLE;
		endcase
	end

	//////////////////////////////
	// Control to the counter and queue

	// tx_ready only matters before a frame begins
	assign len_pop			= (state == UNPACK_IDLE) && !len_empty && tx_ready;
	assign frame_begin		= len_pop;
	assign lane_step		= tx_data_valid;
	assign word_step		= tx_data_valid && (lane == 2'd3);

	//////////////////////////////
	// Store reads and release

	// Next word prefetched at lane 2 to land right after lane 3
	assign rd.rd_en			= (state == UNPACK_DATA_WAIT) ||
							  (tx_data_valid && (lane == 2'd2) && !last_byte);
	assign rd.rd_offset		= (state == UNPACK_DATA_WAIT) ? word_offset : word_offset + 1'b1;

	// Free the packet along with its last byte
	assign rd.pop_packet	= (tx_data_valid && last_byte) ||
							  ((state == UNPACK_DATA_FIRST) && frame_done);
	// Whole words, rounded up
	assign rd.pop_words		= ADDR_BITS'(frame_len[LEN_BITS-1:2]) + ADDR_BITS'(|frame_len[1:0]);

	//////////////////////////////
	// Transmit port

	assign tx_start			= (state == UNPACK_LEN_WAIT);
	assign tx_data_valid	= (state == UNPACK_DATA_REST);

	// MSB first
	always_comb begin
		case (lane)
			2'd0:		tx_data = rd.rd_data[31:24];
			2'd1:		tx_data = rd.rd_data[23:16];
			2'd2:		tx_data = rd.rd_data[15:8];
			default:	tx_data = rd.rd_data[7:0];
		endcase
	end

endmodule

//--- hdl/eth_byte_counter.sv
`include "eth_xover_consts.svh"

module eth_byte_counter import eth_xover_pkg::*; (
	input	logic								rx_clk,
	input	logic								rst_n,
	input	logic								frame_begin,
	input	logic								lane_step,
	input	logic								word_step,
	input	logic [`ETH_LEN_BITS-1:0]			frame_len,
	output	byte_lane_t							lane,
	output	logic [`ETH_STORE_ADDR_BITS-1:0]	word_offset,
	output	logic								last_byte,
	output	logic								frame_done
);

	localparam int unsigned LEN_BITS = `ETH_LEN_BITS;

	// Bytes in whole words already sent
	logic [LEN_BITS-1:0]	bytes_sent;

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			bytes_sent	<= '0;
			word_offset	<= '0;
			lane		<= '0;
		end else if (frame_begin) begin
			bytes_sent	<= '0;
			word_offset	<= '0;
			lane		<= '0;
		end else begin
			// Lane wraps back to 0 after lane 3
			if (lane_step)
				lane	<= lane + 1'b1;
			if (word_step) begin
				bytes_sent	<= bytes_sent + 3'd4;
				word_offset	<= word_offset + 1'b1;
			end
		end
	end

	// Byte on the current lane is the final one
	assign last_byte	= (bytes_sent + LEN_BITS'(lane) + 1'b1) == frame_len;
	// Nothing left, only for an empty frame
	assign frame_done	= bytes_sent >= frame_len;

endmodule

//--- hdl/eth_frame_len_queue.sv
`include "eth_xover_consts.svh"

module eth_frame_len_queue import eth_xover_pkg::*; (
	input	logic							rx_clk,
	input	logic							rst_n,
	input	eth_rx_bus_t					rx_bus,
	input	logic [`ETH_STORE_ADDR_BITS:0]	free_words,
	input	logic							len_pop,
	output	logic							admit,
	output	logic							len_empty,
	output	logic [`ETH_LEN_BITS-1:0]		len_data
);

	localparam int unsigned LEN_BITS = `ETH_LEN_BITS;
	localparam int unsigned PTR_BITS = $clog2(`ETH_LEN_DEPTH);
	localparam int unsigned CNT_BITS = PTR_BITS + 1;
	localparam int unsigned FREE_BITS = `ETH_STORE_ADDR_BITS + 1;

	logic [LEN_BITS-1:0]	frame_bytes;
	logic [LEN_BITS-1:0]	len_mem [0:`ETH_LEN_DEPTH-1];
	logic [CNT_BITS-1:0]	wr_ptr;
	logic [CNT_BITS-1:0]	rd_ptr;
	logic [CNT_BITS-1:0]	mem_count;
	logic					head_valid;
	logic					head_free;
	logic					mem_empty;
	logic					mem_wr;
	logic					push;
	logic					len_full;

	//////////////////////////////
	// Length count and admission

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_bytes	<= '0;
			admit		<= 1'b0;
		end else if (rx_bus.start) begin
			// Need room for a max size frame and a free queue slot
			frame_bytes	<= '0;
			admit		<= (free_words >= FREE_BITS'(`ETH_MAX_FRAME_WORDS)) && !len_full;
		end else if (rx_bus.data_valid) begin
			frame_bytes	<= frame_bytes + LEN_BITS'(rx_bus.bytes_valid);
		end
	end

	//////////////////////////////
	// Length queue

	// Dropped or refused frames never push
	assign push			= rx_bus.commit && admit;
	assign mem_empty	= (wr_ptr == rd_ptr);
	assign mem_count	= wr_ptr - rd_ptr;
	// Head register counts as one entry
	assign len_full		= (mem_count + CNT_BITS'(head_valid)) == CNT_BITS'(`ETH_LEN_DEPTH);
	assign head_free	= !head_valid || len_pop;
	// Straight into the head when nothing is queued behind it
	assign mem_wr		= push && !(head_free && mem_empty);
	assign len_empty	= !head_valid;

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr		<= '0;
			rd_ptr		<= '0;
			head_valid	<= 1'b0;
		end else begin
			if (head_free) begin
				if (!mem_empty) begin
					rd_ptr		<= rd_ptr + 1'b1;
					head_valid	<= 1'b1;
				end else begin
					head_valid	<= push;
				end
			end
			if (mem_wr)
				wr_ptr	<= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge rx_clk) begin
		if (mem_wr)
			len_mem[wr_ptr[PTR_BITS-1:0]]	<= frame_bytes;

		// Head refill, bypass when the queue behind it is empty
		if (head_free)
			len_data	<= mem_empty ? frame_bytes : len_mem[rd_ptr[PTR_BITS-1:0]];
	end

endmodule

//--- hdl/eth_packet_store.sv
`include "eth_xover_consts.svh"

module eth_packet_store import eth_xover_pkg::*; (
	input	logic							rx_clk,
	input	logic							rst_n,
	input	eth_rx_bus_t					rx_bus,
	input	logic							admit,
	output	logic [`ETH_STORE_ADDR_BITS:0]	free_words,
	eth_pkt_rd_if.store						rd
);

	localparam int unsigned ADDR_BITS = `ETH_STORE_ADDR_BITS;
	localparam int unsigned PTR_BITS = `ETH_STORE_ADDR_BITS + 1;

	// Pointers carry one wrap bit so full and empty differ
	logic [PTR_BITS-1:0]		wr_ptr;
	logic [PTR_BITS-1:0]		commit_ptr;
	logic [PTR_BITS-1:0]		head_ptr;

	logic [`ETH_WORD_BITS-1:0]	mem [0:`ETH_STORE_DEPTH-1];
	logic [`ETH_WORD_BITS-1:0]	mem_rd;
	logic [ADDR_BITS-1:0]		rd_addr;
	logic						rd_pending;

	logic						wr_en;
	logic						commit_en;

	//////////////////////////////
	// Write side

	// Only words of an admitted frame are stored
	assign wr_en		= rx_bus.data_valid && admit;
	assign commit_en	= rx_bus.commit && admit;

	// Space left counts words not yet committed too
	assign free_words	= PTR_BITS'(`ETH_STORE_DEPTH) - (wr_ptr - head_ptr);

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr		<= '0;
			commit_ptr	<= '0;
		end else if (rx_bus.drop) begin
			// Roll back everything written since the last commit
			wr_ptr		<= commit_ptr;
		end else begin
			if (wr_en)
				wr_ptr	<= wr_ptr + 1'b1;

			// Commit includes a word written in the same cycle
			if (commit_en) begin
				if (wr_en)
					commit_ptr	<= wr_ptr + 1'b1;
				else
					commit_ptr	<= wr_ptr;
			end
		end
	end

	always_ff @(posedge rx_clk) begin
		if (wr_en)
			mem[wr_ptr[ADDR_BITS-1:0]]	<= rx_bus.data;
	end

	//////////////////////////////
	// Read side

	// Offsets are relative to the oldest packet
	assign rd_addr = head_ptr[ADDR_BITS-1:0] + rd.rd_offset;

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			head_ptr	<= '0;
			rd_pending	<= 1'b0;
		end else begin
			rd_pending	<= rd.rd_en;

			// Whole packet freed at once
			if (rd.pop_packet)
				head_ptr	<= head_ptr + {1'b0, rd.pop_words};
		end
	end

	// Memory read then output register, two cycles in all
	always_ff @(posedge rx_clk) begin
		if (rd.rd_en)
			mem_rd		<= mem[rd_addr];

		// Output holds until the next read comes through
		if (rd_pending)
			rd.rd_data	<= mem_rd;
	end

endmodule

//--- hdl/eth_pkt_rd_if.sv
`include "eth_xover_consts.svh"

interface eth_pkt_rd_if;

	// One cycle read request
	logic								rd_en;
	// Word offset from the head of the oldest committed packet
	logic [`ETH_STORE_ADDR_BITS-1:0]	rd_offset;
	// Frees the oldest packet
	logic								pop_packet;
	// Size of that packet in words
	logic [`ETH_STORE_ADDR_BITS-1:0]	pop_words;
	// Two cycles behind rd_en, then held
	logic [`ETH_WORD_BITS-1:0]			rd_data;

	// Unpacker side
	modport reader (
		output	rd_en,
		output	rd_offset,
		output	pop_packet,
		output	pop_words,
		input	rd_data
	);

	// Memory side
	modport store (
		input	rd_en,
		input	rd_offset,
		input	pop_packet,
		input	pop_words,
		output	rd_data
	);

endinterface

//--- hdl/eth_xover_pkg.sv
`include "eth_xover_consts.svh"

package eth_xover_pkg;

	//////////////////////////////
	// Receive bus

	// One cycle of the 32 bit receive bus
	typedef struct packed {
		// Strobe ahead of the first word of a frame
		logic							start;
		logic							data_valid;
		// Number of valid bytes in data, 1 to 4
		logic [2:0]						bytes_valid;
		// Most significant byte goes out first
		logic [`ETH_WORD_BITS-1:0]		data;
		// End of frame, keep it
		logic							commit;
		// End of frame, throw it away
		logic							drop;
	} eth_rx_bus_t;

	//////////////////////////////
	// Transmit side

	// Unpacker FSM states
	typedef enum logic [2:0] {
		UNPACK_IDLE,
		UNPACK_LEN_WAIT,
		UNPACK_DATA_WAIT,
		UNPACK_DATA_FIRST,
		UNPACK_DATA_REST
	} unpack_state_t;

	// Byte within a word, lane 0 is bits 31 to 24
	typedef logic [1:0] byte_lane_t;

endpackage

//--- hdl/eth_xover_consts.svh
`ifndef ETH_XOVER_CONSTS_SVH
`define ETH_XOVER_CONSTS_SVH

//////////////////////////////
// Receive data path

// Width of one receive bus word
`define ETH_WORD_BITS		32

//////////////////////////////
// Packet store geometry

// 32 bit words, 4 kB in total
`define ETH_STORE_DEPTH		1024
`define ETH_STORE_ADDR_BITS	10

//////////////////////////////
// Length queue and admission

// Frame length in bytes
`define ETH_LEN_BITS		11
// Enough entries for a store full of minimum size frames
`define ETH_LEN_DEPTH		64
// Free words needed to accept a maximum size frame
`define ETH_MAX_FRAME_WORDS	375

`endif
